// ==== hw/vshift_defines.svh ====
//----------------------------------------
// Widths and register map of the vector shift unit
// Include wherever a width or a bus address is needed
//----------------------------------------
`ifndef VSHIFT_DEFINES_SVH
`define VSHIFT_DEFINES_SVH

`define VSHIFT_DATA_W       64
`define VSHIFT_NUM_BYTES    8
`define VSHIFT_BYTE_W       8
`define VSHIFT_NUM_OSIZES   4

`define VSHIFT_WB_DW        32
`define VSHIFT_WB_AW        3

// Word addresses
`define VSHIFT_ADR_SRCA_LO  3'd0
`define VSHIFT_ADR_SRCA_HI  3'd1
`define VSHIFT_ADR_SRCB_LO  3'd2
`define VSHIFT_ADR_SRCB_HI  3'd3
`define VSHIFT_ADR_CTRL     3'd4
`define VSHIFT_ADR_STATUS   3'd5
`define VSHIFT_ADR_RES_LO   3'd6
`define VSHIFT_ADR_RES_HI   3'd7

// CTRL fields, op and osize are 2 bits wide
`define VSHIFT_CTRL_OP_LSB     0
`define VSHIFT_CTRL_OSIZE_LSB  4
`define VSHIFT_CTRL_START_BIT  8

`endif

// ==== hw/vshift_dp_pkg.sv ====
//----------------------------------------
// Datapath types of the packed-SIMD shifter
//----------------------------------------
`default_nettype none

`include "vshift_defines.svh"

package vshift_dp_pkg;

    typedef logic [`VSHIFT_BYTE_W-1:0] byte_t;
    typedef logic [`VSHIFT_DATA_W-1:0] vdata_t;
    typedef byte_t [`VSHIFT_NUM_BYTES-1:0] byte_vec_t;  // Byte view of vdata_t

    // Element width
    typedef enum logic [1:0] {
        E8  = 2'd0,
        E16 = 2'd1,
        E32 = 2'd2,
        E64 = 2'd3
    } osize_e;

    typedef logic [`VSHIFT_NUM_OSIZES-1:0] osize_vec_t;  // One bit per osize
    typedef logic [`VSHIFT_NUM_BYTES-1:0]  merge_vec_t;  // Bit i: bytes i and i+1 share an element

    // Low 3 bits shift inside a byte, upper 3 bits move whole bytes
    typedef logic [5:0] shamt_sel_t;

    typedef enum logic [1:0] {
        SLL = 2'd0,
        SRL = 2'd1,
        SRA = 2'd2  // Code 3 is illegal
    } shift_op_e;

endpackage

`default_nettype wire

// ==== hw/vshift_bus_pkg.sv ====
//----------------------------------------
// Bus side types: Wishbone words, register
// indices and the execute FSM states
//----------------------------------------
`default_nettype none

`include "vshift_defines.svh"

package vshift_bus_pkg;

    typedef logic [`VSHIFT_WB_AW-1:0] wb_adr_t;
    typedef logic [`VSHIFT_WB_DW-1:0] wb_data_t;

    typedef enum logic [`VSHIFT_WB_AW-1:0] {
        REG_SRCA_LO = `VSHIFT_ADR_SRCA_LO,
        REG_SRCA_HI = `VSHIFT_ADR_SRCA_HI,
        REG_SRCB_LO = `VSHIFT_ADR_SRCB_LO,
        REG_SRCB_HI = `VSHIFT_ADR_SRCB_HI,
        REG_CTRL    = `VSHIFT_ADR_CTRL,
        REG_STATUS  = `VSHIFT_ADR_STATUS,
        REG_RES_LO  = `VSHIFT_ADR_RES_LO,
        REG_RES_HI  = `VSHIFT_ADR_RES_HI
    } reg_idx_e;

    typedef enum logic [1:0] {IDLE, EXEC, DONE} exec_state_e;

endpackage

`default_nettype wire

// ==== hw/vshift_op_if.sv ====
//----------------------------------------
// One shift operation from the register block
// to the execute unit, and its reply
//----------------------------------------
`default_nettype none

interface vshift_op_if
    import vshift_dp_pkg::*;
();

    vdata_t    srca;
    vdata_t    srcb;
    shift_op_e op;
    osize_e    osize;
    logic      start;   // One-cycle pulse, never while busy
    logic      busy;
    logic      done;    // One-cycle pulse with result valid
    vdata_t    result;

    modport regs (output srca, srcb, op, osize, start, input busy, done, result);
    modport exec (input srca, srcb, op, osize, start, output busy, done, result);

endinterface

`default_nettype wire

// ==== hw/byte_shifter.sv ====
//----------------------------------------
// Shifts one byte by 0 to 7 bits, filling from
// the neighbour byte or with the sign bit
//----------------------------------------
`default_nettype none

`include "vshift_defines.svh"

module byte_shifter
    import vshift_dp_pkg::*;
(
    input  byte_t                              src,
    input  byte_t                              shift_in,
    input  logic [$clog2(`VSHIFT_BYTE_W)-1:0]  amount,
    input  logic                               shift_left,
    input  logic                               shift_arith,
    output byte_t                              result
);

    localparam int BW = `VSHIFT_BYTE_W;

    byte_t           fill;
    logic [2*BW-1:0] wide;

    // At an element edge the caller passes arith, so src holds the sign
    assign fill = shift_arith ? {BW{src[BW-1]}} : shift_in;

    always_comb begin
        if (shift_left) begin
            wide   = {src, shift_in} << amount;  // Bits enter from the lower byte
            result = wide[2*BW-1:BW];
        end else begin
            wide   = {fill, src} >> amount;
            result = wide[BW-1:0];
        end
    end

endmodule

`default_nettype wire

// ==== hw/osize_decoder.sv ====
//----------------------------------------
// Turns the element size into the per-osize
// and per-byte control vectors of the shifter
//----------------------------------------
`default_nettype none

`include "vshift_defines.svh"

module osize_decoder
    import vshift_dp_pkg::*;
(
    input  osize_e     osize,
    output osize_vec_t osize_vector,
    output osize_vec_t is_less,     // Element no wider than size k
    output osize_vec_t is_greater,  // Element at least as wide as size k
    output merge_vec_t merge
);

    localparam int NB = `VSHIFT_NUM_BYTES;

    always_comb begin
        osize_vector = '0;
        osize_vector[osize] = 1'b1;
        for (int k = 0; k < `VSHIFT_NUM_OSIZES; k++) begin
            is_less[k]    = (k >= int'(osize));
            is_greater[k] = (k <= int'(osize));
        end
    end

    // Byte i+1 starts a new element when it is aligned to the element size
    always_comb begin
        merge = '0;
        for (int i = 0; i < NB - 1; i++) begin
            merge[i] = (((i + 1) & ((1 << osize) - 1)) != 0);
        end
    end

    always_comb begin
        if (!$isunknown(osize)) begin
            assert ($onehot(osize_vector) && ((is_less & is_greater) == osize_vector))
                else $error("osize decode is not one-hot");
        end
    end

endmodule

`default_nettype wire

// ==== hw/vec_shifter.sv ====
//----------------------------------------
// Element-aware byte-sliced shifter
// Left shifts run through the right-shift
// network on a byte-reversed view
//----------------------------------------
`default_nettype none

`include "vshift_defines.svh"

module vec_shifter
    import vshift_dp_pkg::*;
(
    input  shift_op_e  op,
    input  osize_vec_t osize_vector,
    input  osize_vec_t is_less,
    input  osize_vec_t is_greater,
    input  merge_vec_t merge,
    input  vdata_t     srca,
    input  vdata_t     srcb,
    output vdata_t     result
);

    localparam int NB     = `VSHIFT_NUM_BYTES;
    localparam int BW     = `VSHIFT_BYTE_W;
    localparam int BIT_W  = $clog2(BW);   // Sub-byte shift bits
    localparam int STAGES = $clog2(NB);   // Byte mux stages of 1, 2, 4
    localparam int SEL_W  = $bits(shamt_sel_t);

    function automatic int low_zeros(input int v);
        int n;
        n = 0;
        while ((((v >> n) & 1) == 0) && (n < STAGES)) begin
            n++;
        end
        return n;
    endfunction

    logic       shift_left;
    logic       shift_arith;
    byte_vec_t  a_in;
    byte_vec_t  b_in;
    byte_vec_t  a_view;             // srca in shift order
    merge_vec_t merge_view;
    shamt_sel_t amt_raw  [NB];      // Amount of each byte, original order
    shamt_sel_t amt_view [NB];
    logic [NB-1:0] fill_sign;       // Element sign, when arithmetic
    logic [NB-1:0] arith_vec;
    byte_vec_t  stage    [STAGES+1];
    byte_vec_t  shift_in;
    byte_vec_t  res_view;
    byte_vec_t  res_out;

    assign shift_left  = (op == SLL);
    assign shift_arith = (op == SRA);
    assign a_in        = srca;
    assign b_in        = srcb;

    for (genvar i = 0; i < NB; i++) begin : g_amt
        if (i == 0) begin : g_base
            assign amt_raw[i] = b_in[0][SEL_W-1:0];
        end else begin : g_upper
            // An element takes the amount held in its lowest byte
            always_comb begin
                amt_raw[i] = b_in[i][SEL_W-1:0];
                if (!is_less[low_zeros(i)]) begin
                    for (int k = 1; k < `VSHIFT_NUM_OSIZES; k++) begin
                        if (osize_vector[k] && ((i % (1 << k)) != 0)) begin
                            amt_raw[i] = b_in[i - (i % (1 << k))][SEL_W-1:0];
                        end
                    end
                end
            end
        end
    end

    for (genvar j = 0; j < NB; j++) begin : g_swizzle
        assign a_view[j]   = shift_left ? a_in[NB-1-j] : a_in[j];
        assign amt_view[j] = shift_left ? amt_raw[NB-1-j] : amt_raw[j];
        if (j < NB - 1) begin : g_merge
            assign merge_view[j] = shift_left ? merge[NB-2-j] : merge[j];
        end else begin : g_merge_top
            assign merge_view[j] = 1'b0;    // Nothing above the top byte
        end

        always_comb begin
            fill_sign[j] = 1'b0;
            for (int k = 0; k < `VSHIFT_NUM_OSIZES; k++) begin
                if (osize_vector[k]) begin
                    fill_sign[j] = a_view[j | ((1 << k) - 1)][BW-1] & shift_arith;
                end
            end
        end
    end

    assign stage[0] = a_view;

    for (genvar s = 0; s < STAGES; s++) begin : g_stage
        for (genvar i = 0; i < NB; i++) begin : g_mux
            localparam int D = 1 << s;
            logic en;

            assign en = amt_view[i][BIT_W+s] & is_greater[s+1];  // Also masks the amount

            if (i + D < NB) begin : g_inner
                assign stage[s+1][i] = !en ? stage[s][i] :
                                       (&merge_view[i +: D]) ? stage[s][i+D] :
                                       {BW{fill_sign[i]}};
            end else begin : g_edge
                assign stage[s+1][i] = en ? {BW{fill_sign[i]}} : stage[s][i];
            end
        end
    end

    for (genvar j = 0; j < NB; j++) begin : g_bytes
        if (j < NB - 1) begin : g_nb
            assign shift_in[j] = merge_view[j] ? stage[STAGES][j+1] : '0;
        end else begin : g_nb_top
            assign shift_in[j] = '0;
        end
        assign arith_vec[j] = ~merge_view[j] & shift_arith;

        byte_shifter u_byte_shifter (
            .src         (stage[STAGES][j]),
            .shift_in    (shift_in[j]),
            .amount      (amt_view[j][BIT_W-1:0]),
            .shift_left  (shift_left),
            .shift_arith (arith_vec[j]),
            .result      (res_view[j])
        );

        assign res_out[j] = shift_left ? res_view[NB-1-j] : res_view[j];
    end

    assign result = res_out;

    always_comb begin
        if (!$isunknown(op)) begin
            assert (op != 2'd3) else $error("illegal shift op reached the shifter");
        end
    end

endmodule

`default_nettype wire

// ==== hw/vshift_exec.sv ====
//----------------------------------------
// Execute unit: takes one operation on start,
// shifts it and returns the registered result
//----------------------------------------
`default_nettype none

module vshift_exec
    import vshift_dp_pkg::*;
    import vshift_bus_pkg::*;
(
    input logic       clk,
    input logic       rst_n,
    vshift_op_if.exec op_port
);

    exec_state_e state;
    shift_op_e   op_q;
    osize_e      osize_q;
    vdata_t      srca_q;
    vdata_t      srcb_q;
    vdata_t      shift_res;
    vdata_t      result_q;
    logic        done_q;
    osize_vec_t  osize_vec;
    osize_vec_t  is_less;
    osize_vec_t  is_greater;
    merge_vec_t  merge;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= IDLE;
            op_q     <= SLL;
            osize_q  <= E8;
            result_q <= '0;
            done_q   <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state)
                IDLE: if (op_port.start) begin
                    op_q    <= op_port.op;
                    osize_q <= op_port.osize;
                    state   <= EXEC;
                end
                EXEC: begin
                    result_q <= shift_res;
                    done_q   <= 1'b1;
                    state    <= DONE;
                end
                default: state <= IDLE;  // DONE lasts one cycle
            endcase
        end
    end

    // Operand copies
    always_ff @(posedge clk) begin
        if (state == IDLE && op_port.start) begin
            srca_q <= op_port.srca;
            srcb_q <= op_port.srcb;
        end
    end

    osize_decoder u_osize_decoder (
        .osize        (osize_q),
        .osize_vector (osize_vec),
        .is_less      (is_less),
        .is_greater   (is_greater),
        .merge        (merge)
    );

    vec_shifter u_vec_shifter (
        .op           (op_q),
        .osize_vector (osize_vec),
        .is_less      (is_less),
        .is_greater   (is_greater),
        .merge        (merge),
        .srca         (srca_q),
        .srcb         (srcb_q),
        .result       (shift_res)
    );

    assign op_port.busy   = (state != IDLE);
    assign op_port.done   = done_q;
    assign op_port.result = result_q;

    a_no_start_busy: assert property (@(posedge clk) disable iff (!rst_n)
        op_port.start |-> !op_port.busy);
    // Result two cycles after the start pulse
    a_done_after_start: assert property (@(posedge clk) disable iff (!rst_n)
        op_port.start |-> ##2 op_port.done);

endmodule

`default_nettype wire

// ==== hw/wb_vshift_regs.sv ====
//----------------------------------------
// Wishbone classic slave with the operand,
// control, status and result registers
//----------------------------------------
`default_nettype none

`include "vshift_defines.svh"

module wb_vshift_regs
    import vshift_dp_pkg::*;
    import vshift_bus_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     cyc,
    input  logic     stb,
    input  logic     we,
    input  wb_adr_t  adr,
    input  wb_data_t dat_w,
    output wb_data_t dat_r,
    output logic     ack,
    vshift_op_if.regs op_port
);

    localparam int DW = `VSHIFT_WB_DW;

    vdata_t    srca_q;
    vdata_t    srcb_q;
    shift_op_e ctrl_op;
    osize_e    ctrl_osize;
    logic      start_q;
    logic      done_q;
    logic      error_q;
    logic      busy_any;
    logic      wr_en;
    logic      op_bad;
    wb_data_t  rd_mux;

    assign busy_any = start_q | op_port.busy;   // Busy from the start cycle on
    assign wr_en    = ack & cyc & stb & we;      // Write lands at the ack edge
    assign op_bad   = (dat_w[`VSHIFT_CTRL_OP_LSB +: 2] == 2'd3);

    always_comb begin
        rd_mux = '0;
        case (reg_idx_e'(adr))
            REG_SRCA_LO: rd_mux = srca_q[DW-1:0];
            REG_SRCA_HI: rd_mux = srca_q[2*DW-1:DW];
            REG_SRCB_LO: rd_mux = srcb_q[DW-1:0];
            REG_SRCB_HI: rd_mux = srcb_q[2*DW-1:DW];
            REG_CTRL: begin
                rd_mux[`VSHIFT_CTRL_OP_LSB +: 2]    = ctrl_op;
                rd_mux[`VSHIFT_CTRL_OSIZE_LSB +: 2] = ctrl_osize;
            end
            REG_STATUS:  rd_mux[2:0] = {error_q, done_q, busy_any};
            REG_RES_LO:  rd_mux = op_port.result[DW-1:0];
            REG_RES_HI:  rd_mux = op_port.result[2*DW-1:DW];
            default:     rd_mux = '0;
        endcase
    end

    // One wait state, ack drops even if stb stays high
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack   <= 1'b0;
            dat_r <= '0;
        end else begin
            ack <= cyc & stb & ~ack;
            if (cyc && stb && !ack) begin
                dat_r <= rd_mux;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            srca_q     <= '0;
            srcb_q     <= '0;
            ctrl_op    <= SLL;
            ctrl_osize <= E8;
            start_q    <= 1'b0;
            done_q     <= 1'b0;
            error_q    <= 1'b0;
        end else begin
            start_q <= 1'b0;
            if (op_port.done) begin
                done_q <= 1'b1;    // Sticky until the next start
            end
            if (wr_en) begin
                case (reg_idx_e'(adr))
                    REG_SRCA_LO: srca_q[DW-1:0]    <= dat_w;
                    REG_SRCA_HI: srca_q[2*DW-1:DW] <= dat_w;
                    REG_SRCB_LO: srcb_q[DW-1:0]    <= dat_w;
                    REG_SRCB_HI: srcb_q[2*DW-1:DW] <= dat_w;
                    REG_CTRL: if (!busy_any) begin
                        ctrl_op    <= shift_op_e'(dat_w[`VSHIFT_CTRL_OP_LSB +: 2]);
                        ctrl_osize <= osize_e'(dat_w[`VSHIFT_CTRL_OSIZE_LSB +: 2]);
                        if (dat_w[`VSHIFT_CTRL_START_BIT]) begin
                            done_q  <= 1'b0;
                            error_q <= op_bad;
                            start_q <= ~op_bad;
                        end
                    end
                    default: ;  // STATUS and RES are read only
                endcase
            end
        end
    end

    assign op_port.srca  = srca_q;
    assign op_port.srcb  = srcb_q;
    assign op_port.op    = ctrl_op;
    assign op_port.osize = ctrl_osize;
    assign op_port.start = start_q;

    a_ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(ack) |-> $past(cyc && stb));

endmodule

`default_nettype wire

// ==== hw/vshift_top.sv ====
//----------------------------------------
// Vector shift unit behind a Wishbone classic
// slave port, one operation at a time
//----------------------------------------
`default_nettype none

module vshift_top
    import vshift_bus_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     cyc,
    input  logic     stb,
    input  logic     we,
    input  wb_adr_t  adr,
    input  wb_data_t dat_w,
    output wb_data_t dat_r,
    output logic     ack
);

    vshift_op_if op_bus ();

    wb_vshift_regs u_regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .cyc     (cyc),
        .stb     (stb),
        .we      (we),
        .adr     (adr),
        .dat_w   (dat_w),
        .dat_r   (dat_r),
        .ack     (ack),
        .op_port (op_bus.regs)
    );

    vshift_exec u_exec (
        .clk     (clk),
        .rst_n   (rst_n),
        .op_port (op_bus.exec)
    );

endmodule

`default_nettype wire

// ==== dv/tb_vshift_top.sv ====
//----------------------------------------
// Directed and random testbench for the vector
// shift unit, driven over its Wishbone port
//----------------------------------------
`default_nettype none

`include "vshift_defines.svh"

module tb_vshift_top
    import vshift_dp_pkg::*;
    import vshift_bus_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_OPS       = 240;  // Upper bound on shift operations in the run
    localparam int CYCLES_PER_OP = 200;
    localparam int ACK_LIMIT     = 16;
    localparam int POLL_LIMIT    = 20;

    logic     clk;
    logic     rst_n;
    logic     cyc;
    logic     stb;
    logic     we;
    wb_adr_t  adr;
    wb_data_t dat_w;
    wb_data_t dat_r;
    logic     ack;
    int       err_count;
    vdata_t   last_res;   // RES as left by the last completed operation

    vshift_top DUT (
        .clk   (clk),
        .rst_n (rst_n),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .dat_w (dat_w),
        .dat_r (dat_r),
        .ack   (ack)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        err_count++;
        $display("*** FAILED ***");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(input string name, input vdata_t got, input vdata_t exp);
        assert (got === exp) else begin
            report_failure($sformatf("error at %0t ns: %s is %h, expected %h",
                                     $time, name, got, exp));
        end
    endtask

    // Each element shifted on its own, amount from the low log2(width) bits
    function automatic vdata_t shift_model(input shift_op_e op, input osize_e osz,
                                           input vdata_t a, input vdata_t b);
        int     width;
        int     amt;
        vdata_t mask;
        vdata_t elem;
        vdata_t out;
        vdata_t res;
        res   = '0;
        width = 8 << int'(osz);
        mask  = (width == 64) ? '1 : ((64'd1 << width) - 64'd1);
        for (int base = 0; base < 64; base += width) begin
            elem = (a >> base) & mask;
            amt  = int'((b >> base) & vdata_t'(width - 1));
            case (op)
                SLL: out = (elem << amt) & mask;
                SRL: out = elem >> amt;
                default: begin
                    out = elem >> amt;
                    if (elem[width-1]) begin
                        out = out | (mask & ~(mask >> amt));  // Sign fill at the top
                    end
                end
            endcase
            res = res | (out << base);
        end
        return res;
    endfunction

    function automatic wb_data_t ctrl_word(input logic [1:0] op, input logic [1:0] osz,
                                           input logic start);
        wb_data_t w;
        w = '0;
        w[`VSHIFT_CTRL_OP_LSB +: 2]    = op;
        w[`VSHIFT_CTRL_OSIZE_LSB +: 2] = osz;
        w[`VSHIFT_CTRL_START_BIT]      = start;
        return w;
    endfunction

    // Called on a falling edge, returns on a falling edge
    task automatic wb_access(input logic write, input wb_adr_t addr, input wb_data_t wdata,
                             output wb_data_t rdata);
        int waited;
        waited = 0;
        cyc    = 1'b1;
        stb    = 1'b1;
        we     = write;
        adr    = addr;
        dat_w  = wdata;
        @(negedge clk);
        while (ack !== 1'b1) begin
            waited++;
            if (waited > ACK_LIMIT) begin
                report_failure("Wishbone slave never acknowledged the access");
            end
            @(negedge clk);
        end
        rdata = dat_r;
        @(negedge clk);   // Write has landed on this edge
        check_value("ack", vdata_t'(ack), '0);
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
    endtask

    task automatic wb_write(input wb_adr_t addr, input wb_data_t data);
        wb_data_t unused;
        wb_access(1'b1, addr, data, unused);
    endtask

    task automatic wb_read(input wb_adr_t addr, output wb_data_t data);
        wb_access(1'b0, addr, '0, data);
    endtask

    task automatic read_result(output vdata_t res);
        wb_data_t lo;
        wb_data_t hi;
        wb_read(`VSHIFT_ADR_RES_LO, lo);
        wb_read(`VSHIFT_ADR_RES_HI, hi);
        res = {hi, lo};
    endtask

    task automatic run_op(input shift_op_e op, input osize_e osz, input vdata_t a,
                          input vdata_t b);
        wb_data_t status;
        vdata_t   expected;
        vdata_t   res;
        int       polls;
        expected = shift_model(op, osz, a, b);
        wb_write(`VSHIFT_ADR_SRCA_LO, a[31:0]);
        wb_write(`VSHIFT_ADR_SRCA_HI, a[63:32]);
        wb_write(`VSHIFT_ADR_SRCB_LO, b[31:0]);
        wb_write(`VSHIFT_ADR_SRCB_HI, b[63:32]);
        wb_write(`VSHIFT_ADR_CTRL, ctrl_word(op, osz, 1'b1));
        polls = 0;
        wb_read(`VSHIFT_ADR_STATUS, status);
        while (!status[1]) begin
            polls++;
            if (polls > POLL_LIMIT) begin
                report_failure("STATUS never showed done after a start");
            end
            wb_read(`VSHIFT_ADR_STATUS, status);
        end
        check_value("STATUS", vdata_t'(status), 64'h2);   // Done only, no busy or error
        read_result(res);
        check_value($sformatf("RES (op %0d osize %0d)", op, osz), res, expected);
        last_res = res;
    endtask

    task automatic run_all_ops(input osize_e osz, input vdata_t a, input vdata_t b);
        run_op(SLL, osz, a, b);
        run_op(SRL, osz, a, b);
        run_op(SRA, osz, a, b);
    endtask

    task automatic test_register_access();
        wb_data_t rd;
        wb_data_t wr;
        vdata_t   res;
        wb_read(`VSHIFT_ADR_STATUS, rd);
        check_value("STATUS", vdata_t'(rd), '0);
        read_result(res);
        check_value("RES", res, '0);
        for (int i = 0; i < 4; i++) begin   // SRCA_LO up to SRCB_HI
            wr = $urandom;
            wb_write(wb_adr_t'(i), wr);
            wb_read(wb_adr_t'(i), rd);
            check_value($sformatf("operand word %0d", i), vdata_t'(rd), vdata_t'(wr));
        end
    endtask

    task automatic test_e8_directed();
        run_all_ops(E8, 64'h807F_F00F_8155_AA01, 64'h0701_0007_0100_0701);
        run_all_ops(E8, 64'hFFFE_80C3_7F01_00A5, 64'h0007_0107_0001_0700);
    endtask

    task automatic test_cross_byte();
        run_all_ops(E16, 64'h8001_F00F_7FFF_C3A5, 64'h0009_000F_0001_0008);
        run_all_ops(E32, 64'h8765_4321_F0E1_D2C3, 64'h0000_0009_0000_0011);
        run_all_ops(E32, 64'h7FFF_0001_8000_00FF, 64'h0000_001F_0000_0008);
        run_all_ops(E64, 64'hF123_4567_89AB_CDEF, 64'd40);
        run_all_ops(E64, 64'h0123_4567_89AB_CDEF, 64'd63);
    endtask

    task automatic test_amount_masking();
        vdata_t a;
        a = 64'hC3A5_8001_7F10_FE01;
        run_all_ops(E8,  a, 64'hF9FA_FBF8_C917_2FFF);
        run_all_ops(E16, a, 64'hFF13_0010_8001_7FF7);
        run_all_ops(E32, a, 64'h0000_0123_FFFF_FFE9);
        run_all_ops(E64, a, 64'hFFFF_FFFF_FFFF_FFC5);
    endtask

    task automatic test_random_ops();
        shift_op_e op;
        osize_e    osz;
        vdata_t    a;
        vdata_t    b;
        for (int n = 0; n < 200; n++) begin
            op  = shift_op_e'(2'($urandom_range(2, 0)));
            osz = osize_e'(2'($urandom_range(3, 0)));
            a   = {$urandom, $urandom};
            b   = {$urandom, $urandom};
            run_op(op, osz, a, b);
        end
    endtask

    task automatic test_control_errors();
        wb_data_t status;
        vdata_t   res;
        wb_write(`VSHIFT_ADR_CTRL, ctrl_word(2'd3, 2'(E16), 1'b1));
        wb_read(`VSHIFT_ADR_STATUS, status);
        check_value("STATUS", vdata_t'(status), 64'h4);  // Error set, nothing started
        read_result(res);
        check_value("RES", res, last_res);
        run_op(SRA, E32, 64'h8000_0001_7FFF_FFFF, 64'h0000_0004_0000_0021);
    endtask

    // Ends a hung run
    initial begin
        repeat (NUM_OPS * CYCLES_PER_OP) @(posedge clk);
        report_failure("watchdog timeout, the tests did not finish in time");
    end

    initial begin
        void'($urandom(7));
        err_count = 0;
        last_res  = '0;
        rst_n     = 1'b0;
        cyc       = 1'b0;
        stb       = 1'b0;
        we        = 1'b0;
        adr       = '0;
        dat_w     = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        test_register_access();
        test_e8_directed();
        test_cross_byte();
        test_amount_masking();
        test_random_ops();
        test_control_errors();

        if (err_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+hw
hw/vshift_dp_pkg.sv
hw/vshift_bus_pkg.sv
hw/vshift_op_if.sv
hw/byte_shifter.sv
hw/osize_decoder.sv
hw/vec_shifter.sv
hw/vshift_exec.sv
hw/wb_vshift_regs.sv
hw/vshift_top.sv
dv/tb_vshift_top.sv

// ==== Makefile ====
TOOL       = verilator
FLAGS      = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
TOP        = tb_vshift_top
FILELIST   = filelist.f
LOG        = sim.log

.PHONY: all run lint clean

all: run

run:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -qF '*** PASSED ***' $(LOG)

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)
